/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mips_core_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit
  import mips_pkg::*;
(
  input  wire logic [OPCODE_W-1:0] i_opcode,
  input  wire logic [FUNCT_W-1:0]  i_funct,
  output alu_op_e                  o_alu_op,
  output logic                     o_alu_src_imm,
  output logic                     o_reg_write,
  output logic                     o_dest_rt,
  output ext_mode_e                o_ext_mode
);

  always_comb begin
    // Anything unrecognised falls out as a no-op
    o_alu_op      = ALU_ADD;
    o_alu_src_imm = 1'b0;
    o_reg_write   = 1'b0;
    o_dest_rt     = 1'b0;
    o_ext_mode    = EXT_SIGN;

    case (i_opcode)
      OP_RTYPE: begin
        o_reg_write = 1'b1;  // Cleared below on a bad funct
        case (i_funct)
          FN_ADD:  o_alu_op = ALU_ADD;
          FN_SUB:  o_alu_op = ALU_SUB;
          FN_AND:  o_alu_op = ALU_AND;
          FN_OR:   o_alu_op = ALU_OR;
          FN_SLT:  o_alu_op = ALU_SLT;
          default: o_reg_write = 1'b0;
        endcase
      end
      OP_ADDI, OP_ANDI, OP_ORI, OP_LUI: begin
        o_alu_src_imm = 1'b1;
        o_reg_write   = 1'b1;
        o_dest_rt     = 1'b1;  // I-format writes rt
        case (i_opcode)
          OP_ANDI: begin
            o_alu_op   = ALU_AND;
            o_ext_mode = EXT_ZERO;  // Logical ops take zero extension
          end
          OP_ORI: begin
            o_alu_op   = ALU_OR;
            o_ext_mode = EXT_ZERO;
          end
          OP_LUI: begin
            o_alu_op   = ALU_LUI;
            o_ext_mode = EXT_UPPER;
          end
          default: o_alu_op = ALU_ADD;  // ADDI
        endcase
      end
      default: ;
    endcase
  end

  always_comb begin
    assert (o_ext_mode inside {EXT_SIGN, EXT_ZERO, EXT_UPPER})
      else $error("control_unit: unused extension mode %b", o_ext_mode);
  end

endmodule

`default_nettype wire

/* rtl/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage
  import mips_pkg::*;
(
  input  wire logic                  i_clk,
  input  wire logic                  i_rst_n,
  input  wire logic                  i_step,
  input  wire logic [DATA_W-1:0]     i_instruction,
  input  wire logic [REG_ADDR_W-1:0] i_dbg_addr,
  input  wire logic                  i_wr_en,      // From writeback
  input  wire logic [REG_ADDR_W-1:0] i_wr_addr,
  input  wire logic [DATA_W-1:0]     i_wr_data,
  output logic      [REG_ADDR_W-1:0] o_ex_rs_addr,
  output logic      [REG_ADDR_W-1:0] o_ex_rt_addr,
  output logic      [DATA_W-1:0]     o_ex_rs_data,
  output logic      [DATA_W-1:0]     o_ex_rt_data,
  output logic      [DATA_W-1:0]     o_ex_imm,
  output alu_op_e                    o_ex_alu_op,
  output logic                       o_ex_alu_src_imm,
  output logic                       o_ex_reg_write,
  output logic      [REG_ADDR_W-1:0] o_ex_dest_addr,
  output logic      [DATA_W-1:0]     o_dbg_data
);

  instr_u                  instr;
  alu_op_e                 alu_op;
  ext_mode_e               ext_mode;
  logic                    alu_src_imm;
  logic                    reg_write;
  logic                    dest_rt;
  logic [DATA_W-1:0]       rs_data;
  logic [DATA_W-1:0]       rt_data;
  logic [DATA_W-1:0]       imm_ext;
  logic [REG_ADDR_W-1:0]   dest_addr;

  assign instr = i_instruction;

  control_unit control_unit_i (
    .i_opcode      (instr.r.opcode),
    .i_funct       (instr.r.funct),
    .o_alu_op      (alu_op),
    .o_alu_src_imm (alu_src_imm),
    .o_reg_write   (reg_write),
    .o_dest_rt     (dest_rt),
    .o_ext_mode    (ext_mode)
  );

  register_file register_file_i (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_step     (i_step),
    .i_rs_addr  (instr.r.rs),
    .i_rt_addr  (instr.r.rt),
    .i_dbg_addr (i_dbg_addr),
    .i_wr_en    (i_wr_en),
    .i_wr_addr  (i_wr_addr),
    .i_wr_data  (i_wr_data),
    .o_rs_data  (rs_data),
    .o_rt_data  (rt_data),
    .o_dbg_data (o_dbg_data)
  );

  // Immediate extender
  always_comb begin
    case (ext_mode)
      EXT_SIGN:  imm_ext = {{(DATA_W-IMM_W){instr.i.imm[IMM_W-1]}}, instr.i.imm};
      EXT_ZERO:  imm_ext = {{(DATA_W-IMM_W){1'b0}}, instr.i.imm};
      EXT_UPPER: imm_ext = {instr.i.imm, {(DATA_W-IMM_W){1'b0}}};
      default:   imm_ext = '0;
    endcase
  end

  assign dest_addr = dest_rt ? instr.i.rt : instr.r.rd;

  // Decode/execute register, a no-op after reset
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_ex_rs_addr     <= '0;
      o_ex_rt_addr     <= '0;
      o_ex_rs_data     <= '0;
      o_ex_rt_data     <= '0;
      o_ex_imm         <= '0;
      o_ex_alu_op      <= ALU_ADD;
      o_ex_alu_src_imm <= 1'b0;
      o_ex_reg_write   <= 1'b0;
      o_ex_dest_addr   <= '0;
    end else if (i_step) begin
      o_ex_rs_addr     <= instr.r.rs;
      o_ex_rt_addr     <= instr.r.rt;
      o_ex_rs_data     <= rs_data;
      o_ex_rt_data     <= rt_data;
      o_ex_imm         <= imm_ext;
      o_ex_alu_op      <= alu_op;
      o_ex_alu_src_imm <= alu_src_imm;
      o_ex_reg_write   <= reg_write;
      o_ex_dest_addr   <= dest_addr;
    end
  end

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage
  import mips_pkg::*;
(
  input  wire logic                  i_clk,
  input  wire logic                  i_rst_n,
  input  wire logic                  i_step,
  input  wire logic [REG_ADDR_W-1:0] i_ex_rs_addr,
  input  wire logic [REG_ADDR_W-1:0] i_ex_rt_addr,
  input  wire logic [DATA_W-1:0]     i_ex_rs_data,
  input  wire logic [DATA_W-1:0]     i_ex_rt_data,
  input  wire logic [DATA_W-1:0]     i_ex_imm,
  input  wire alu_op_e               i_ex_alu_op,
  input  wire logic                  i_ex_alu_src_imm,
  input  wire logic                  i_ex_reg_write,
  input  wire logic [REG_ADDR_W-1:0] i_ex_dest_addr,
  output logic                       o_wb_reg_write,
  output logic      [REG_ADDR_W-1:0] o_wb_reg_addr,
  output logic      [DATA_W-1:0]     o_wb_data
);

  logic              fwd_ok;
  logic [DATA_W-1:0] op_a;
  logic [DATA_W-1:0] op_b_reg;
  logic [DATA_W-1:0] op_b;
  logic [DATA_W-1:0] alu_result;

  // Writeback holds the one result the decoded operands can miss
  assign fwd_ok = o_wb_reg_write && (o_wb_reg_addr != '0);

  assign op_a     = (fwd_ok && (i_ex_rs_addr == o_wb_reg_addr)) ? o_wb_data : i_ex_rs_data;
  assign op_b_reg = (fwd_ok && (i_ex_rt_addr == o_wb_reg_addr)) ? o_wb_data : i_ex_rt_data;
  assign op_b     = i_ex_alu_src_imm ? i_ex_imm : op_b_reg;

  always_comb begin
    case (i_ex_alu_op)
      ALU_ADD: alu_result = op_a + op_b;  // Wraps
      ALU_SUB: alu_result = op_a - op_b;
      ALU_AND: alu_result = op_a & op_b;
      ALU_OR:  alu_result = op_a | op_b;
      ALU_SLT: begin
        // Signed compare
        alu_result = ($signed(op_a) < $signed(op_b)) ? DATA_W'(1) : '0;
      end
      ALU_LUI: alu_result = i_ex_imm;
      default: alu_result = '0;
    endcase
  end

  // Execute/writeback register
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_wb_reg_write <= 1'b0;
      o_wb_reg_addr  <= '0;
      o_wb_data      <= '0;
    end else if (i_step) begin
      o_wb_reg_write <= i_ex_reg_write;
      o_wb_reg_addr  <= i_ex_dest_addr;
      o_wb_data      <= alu_result;
    end
  end

  a_wb_idle_after_reset : assert property (
    @(posedge i_clk) !i_rst_n |=> !o_wb_reg_write
  ) else $error("execute_stage: writeback enabled right after reset");

endmodule

`default_nettype wire

/* rtl/mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_core
  import mips_pkg::*;
(
  input  wire logic                  i_clk,
  input  wire logic                  i_rst_n,
  input  wire logic                  i_step,
  input  wire logic [DATA_W-1:0]     i_instruction,
  input  wire logic [REG_ADDR_W-1:0] i_dbg_reg_addr,
  output logic      [DATA_W-1:0]     o_dbg_reg_data,
  output logic                       o_wb_reg_write,
  output logic      [REG_ADDR_W-1:0] o_wb_reg_addr,
  output logic      [DATA_W-1:0]     o_wb_data
);

  logic [REG_ADDR_W-1:0] ex_rs_addr;
  logic [REG_ADDR_W-1:0] ex_rt_addr;
  logic [DATA_W-1:0]     ex_rs_data;
  logic [DATA_W-1:0]     ex_rt_data;
  logic [DATA_W-1:0]     ex_imm;
  alu_op_e               ex_alu_op;
  logic                  ex_alu_src_imm;
  logic                  ex_reg_write;
  logic [REG_ADDR_W-1:0] ex_dest_addr;

  decode_stage decode_stage_i (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_step           (i_step),
    .i_instruction    (i_instruction),
    .i_dbg_addr       (i_dbg_reg_addr),
    .i_wr_en          (o_wb_reg_write),  // Writeback loops back here
    .i_wr_addr        (o_wb_reg_addr),
    .i_wr_data        (o_wb_data),
    .o_ex_rs_addr     (ex_rs_addr),
    .o_ex_rt_addr     (ex_rt_addr),
    .o_ex_rs_data     (ex_rs_data),
    .o_ex_rt_data     (ex_rt_data),
    .o_ex_imm         (ex_imm),
    .o_ex_alu_op      (ex_alu_op),
    .o_ex_alu_src_imm (ex_alu_src_imm),
    .o_ex_reg_write   (ex_reg_write),
    .o_ex_dest_addr   (ex_dest_addr),
    .o_dbg_data       (o_dbg_reg_data)
  );

  execute_stage execute_stage_i (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_step           (i_step),
    .i_ex_rs_addr     (ex_rs_addr),
    .i_ex_rt_addr     (ex_rt_addr),
    .i_ex_rs_data     (ex_rs_data),
    .i_ex_rt_data     (ex_rt_data),
    .i_ex_imm         (ex_imm),
    .i_ex_alu_op      (ex_alu_op),
    .i_ex_alu_src_imm (ex_alu_src_imm),
    .i_ex_reg_write   (ex_reg_write),
    .i_ex_dest_addr   (ex_dest_addr),
    .o_wb_reg_write   (o_wb_reg_write),
    .o_wb_reg_addr    (o_wb_reg_addr),
    .o_wb_data        (o_wb_data)
  );

endmodule

`default_nettype wire

/* rtl/mips_pkg.sv */
`default_nettype none

package mips_pkg;

  // Widths
  localparam int DATA_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int OPCODE_W   = 6;
  localparam int FUNCT_W    = 6;
  localparam int IMM_W      = 16;
  localparam int NUM_REGS   = 32;

  // Opcode field, bits 31:26
  localparam logic [OPCODE_W-1:0] OP_RTYPE = 6'h00;
  localparam logic [OPCODE_W-1:0] OP_ADDI  = 6'h08;
  localparam logic [OPCODE_W-1:0] OP_ANDI  = 6'h0C;
  localparam logic [OPCODE_W-1:0] OP_ORI   = 6'h0D;
  localparam logic [OPCODE_W-1:0] OP_LUI   = 6'h0F;

  // Funct field for R-format, bits 5:0
  localparam logic [FUNCT_W-1:0] FN_ADD = 6'h20;
  localparam logic [FUNCT_W-1:0] FN_SUB = 6'h22;
  localparam logic [FUNCT_W-1:0] FN_AND = 6'h24;
  localparam logic [FUNCT_W-1:0] FN_OR  = 6'h25;
  localparam logic [FUNCT_W-1:0] FN_SLT = 6'h2A;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4,
    ALU_LUI = 3'd5   // Extended immediate straight through
  } alu_op_e;

  // 2'b11 is left unused
  typedef enum logic [1:0] {
    EXT_SIGN  = 2'b00,
    EXT_ZERO  = 2'b01,
    EXT_UPPER = 2'b10
  } ext_mode_e;

  // One instruction word, two field layouts
  typedef union packed {
    struct packed {
      logic [OPCODE_W-1:0]   opcode;
      logic [REG_ADDR_W-1:0] rs;
      logic [REG_ADDR_W-1:0] rt;
      logic [REG_ADDR_W-1:0] rd;
      logic [4:0]            shamt;  // Not used by this subset
      logic [FUNCT_W-1:0]    funct;
    } r;
    struct packed {
      logic [OPCODE_W-1:0]   opcode;
      logic [REG_ADDR_W-1:0] rs;
      logic [REG_ADDR_W-1:0] rt;
      logic [IMM_W-1:0]      imm;
    } i;
  } instr_u;

endpackage

`default_nettype wire

/* rtl/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file
  import mips_pkg::*;
(
  input  wire logic                  i_clk,
  input  wire logic                  i_rst_n,
  input  wire logic                  i_step,
  input  wire logic [REG_ADDR_W-1:0] i_rs_addr,
  input  wire logic [REG_ADDR_W-1:0] i_rt_addr,
  input  wire logic [REG_ADDR_W-1:0] i_dbg_addr,
  input  wire logic                  i_wr_en,
  input  wire logic [REG_ADDR_W-1:0] i_wr_addr,
  input  wire logic [DATA_W-1:0]     i_wr_data,
  output logic      [DATA_W-1:0]     o_rs_data,
  output logic      [DATA_W-1:0]     o_rt_data,
  output logic      [DATA_W-1:0]     o_dbg_data
);

  logic [DATA_W-1:0] regs [NUM_REGS];
  logic              wr_fire;

  // Register 0 is never written, so it stays at its reset value
  assign wr_fire = i_step && i_wr_en && (i_wr_addr != '0);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_fire) begin
      regs[i_wr_addr] <= i_wr_data;
    end
  end

  // Write-through so a reader two behind the writer sees fresh data
  assign o_rs_data = (wr_fire && (i_wr_addr == i_rs_addr)) ? i_wr_data : regs[i_rs_addr];
  assign o_rt_data = (wr_fire && (i_wr_addr == i_rt_addr)) ? i_wr_data : regs[i_rt_addr];

  assign o_dbg_data = regs[i_dbg_addr];  // Array only, no bypass

  a_reg0_zero : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    ((i_rs_addr == '0) |-> (o_rs_data == '0)) and
    ((i_rt_addr == '0) |-> (o_rt_data == '0)) and
    ((i_dbg_addr == '0) |-> (o_dbg_data == '0))
  ) else $error("register_file: register 0 read nonzero");

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
rtl/mips_pkg.sv
rtl/control_unit.sv
rtl/register_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mips_core.sv
verif/mips_core_tb.sv

/* include/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int NUM_VECTORS = 20;

// Register contents r0..r7 once the pipeline has drained
localparam logic [DATA_W-1:0] FINAL_REGS [8] = '{
  32'h0000_0000, 32'h0000_0001, 32'h0000_0006, 32'h0000_0000,
  32'h0000_0007, 32'h0000_0000, 32'h0000_0001, 32'h1234_8F0D
};

task automatic load_vectors();
  // Columns: instruction, step, expected write, expected address, expected data
  add_vector(encode_i(OP_ORI, 5'd1, 5'd0, 16'h8001), 1'b1, 1'b1, 5'd1, 32'h0000_8001);
  add_vector(encode_i(OP_ADDI, 5'd2, 5'd0, 16'hFFFC), 1'b1, 1'b1, 5'd2, 32'hFFFF_FFFC);
  add_vector(encode_i(OP_ANDI, 5'd3, 5'd2, 16'h8F0F), 1'b1, 1'b1, 5'd3, 32'h0000_8F0C);
  add_vector(encode_i(OP_LUI, 5'd4, 5'd0, 16'h1234), 1'b1, 1'b1, 5'd4, 32'h1234_0000);
  add_vector(encode_r(FN_ADD, 5'd5, 5'd4, 5'd1), 1'b1, 1'b1, 5'd5, 32'h1234_8001);
  add_vector(encode_r(FN_SUB, 5'd6, 5'd5, 5'd2), 1'b1, 1'b1, 5'd6, 32'h1234_8005);
  add_vector(encode_r(FN_AND, 5'd7, 5'd6, 5'd5), 1'b1, 1'b1, 5'd7, 32'h1234_8001);
  add_vector(encode_r(FN_OR, 5'd7, 5'd7, 5'd3), 1'b1, 1'b1, 5'd7, 32'h1234_8F0D);
  add_vector(encode_r(FN_SLT, 5'd1, 5'd2, 5'd7), 1'b1, 1'b1, 5'd1, 32'h0000_0001);
  add_vector(encode_r(FN_SLT, 5'd3, 5'd7, 5'd2), 1'b1, 1'b1, 5'd3, 32'h0000_0000);
  // Write to r0 shows at writeback but never lands
  add_vector(encode_i(OP_ADDI, 5'd0, 5'd5, 16'h0055), 1'b1, 1'b1, 5'd0, 32'h1234_8056);
  add_vector(encode_r(FN_ADD, 5'd6, 5'd0, 5'd1), 1'b1, 1'b1, 5'd6, 32'h0000_0001);
  add_vector(encode_i(OP_ADDI, 5'd4, 5'd0, 16'h0007), 1'b1, 1'b1, 5'd4, 32'h0000_0007);
  add_vector(NOP_INSTR, 1'b0, 1'b0, 5'd0, 32'h0);
  add_vector(NOP_INSTR, 1'b0, 1'b0, 5'd0, 32'h0);
  add_vector(encode_r(FN_SUB, 5'd2, 5'd4, 5'd6), 1'b1, 1'b1, 5'd2, 32'h0000_0006);
  add_vector(encode_i(6'h3F, 5'd5, 5'd1, 16'h1234), 1'b1, 1'b0, 5'd0, 32'h0);
  add_vector(encode_r(6'h27, 5'd7, 5'd1, 5'd2), 1'b1, 1'b0, 5'd0, 32'h0);  // NOR, not decoded
  add_vector(NOP_INSTR, 1'b0, 1'b0, 5'd0, 32'h0);
  add_vector(encode_r(FN_SLT, 5'd5, 5'd2, 5'd6), 1'b1, 1'b1, 5'd5, 32'h0000_0000);
endtask

`endif

/* verif/mips_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_core_tb
  import mips_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  localparam logic [DATA_W-1:0] NOP_INSTR = '0;

  typedef struct {
    logic [DATA_W-1:0]     instr;
    logic                  step;
    logic                  wr;
    logic [REG_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     data;
  } vector_t;

  logic                  i_clk;
  logic                  i_rst_n;
  logic                  i_step;
  logic [DATA_W-1:0]     i_instruction;
  logic [REG_ADDR_W-1:0] i_dbg_reg_addr;
  logic [DATA_W-1:0]     o_dbg_reg_data;
  logic                  o_wb_reg_write;
  logic [REG_ADDR_W-1:0] o_wb_reg_addr;
  logic [DATA_W-1:0]     o_wb_data;

  vector_t vectors[$];
  vector_t pending[$];     // Stepped but not yet seen at writeback
  string   pending_name[$];
  int      error_count = 0;
  int      test_count = 0;
  int      failed_count = 0;

  mips_core mips_core_i (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_step         (i_step),
    .i_instruction  (i_instruction),
    .i_dbg_reg_addr (i_dbg_reg_addr),
    .o_dbg_reg_data (o_dbg_reg_data),
    .o_wb_reg_write (o_wb_reg_write),
    .o_wb_reg_addr  (o_wb_reg_addr),
    .o_wb_data      (o_wb_data)
  );

  function automatic logic [DATA_W-1:0] encode_r(input logic [FUNCT_W-1:0] funct,
      input logic [REG_ADDR_W-1:0] rd, input logic [REG_ADDR_W-1:0] rs,
      input logic [REG_ADDR_W-1:0] rt);
    instr_u w;
    w = '0;
    w.r.opcode = OP_RTYPE;
    w.r.rs = rs;
    w.r.rt = rt;
    w.r.rd = rd;
    w.r.funct = funct;
    return w;
  endfunction

  function automatic logic [DATA_W-1:0] encode_i(input logic [OPCODE_W-1:0] opcode,
      input logic [REG_ADDR_W-1:0] rt, input logic [REG_ADDR_W-1:0] rs,
      input logic [IMM_W-1:0] imm);
    instr_u w;
    w.i.opcode = opcode;
    w.i.rs = rs;
    w.i.rt = rt;
    w.i.imm = imm;
    return w;
  endfunction

  task automatic add_vector(input logic [DATA_W-1:0] instr, input logic step,
      input logic wr, input logic [REG_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    vector_t v;
    v.instr = instr;
    v.step = step;
    v.wr = wr;
    v.addr = addr;
    v.data = data;
    vectors.push_back(v);
  endtask

  `include "tb_vectors.svh"

  task automatic check_word(input string name, input logic [DATA_W-1:0] got,
      input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic close_test(input string label, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
      $display("%s: ok", label);
    end else begin
      failed_count++;
      $display("%s: %0d mismatch(es)", label, error_count - errors_before);
    end
  endtask

  // Sweep r0..r7 over the debug port, one register per cycle
  task automatic sweep_registers(input string label, input logic use_final);
    int errors_before;
    errors_before = error_count;
    for (int r = 0; r < 8; r++) begin
      @(posedge i_clk);
      #1;
      i_dbg_reg_addr = REG_ADDR_W'(r);
      #1;
      check_word($sformatf("o_dbg_reg_data[r%0d]", r), o_dbg_reg_data,
                 use_final ? FINAL_REGS[r] : '0);
    end
    close_test(label, errors_before);
  endtask

  // Step edge just passed, the oldest pending result sits in writeback now
  task automatic check_writeback();
    vector_t exp;
    string   label;
    int      errors_before;
    exp = pending.pop_front();
    label = pending_name.pop_front();
    errors_before = error_count;
    check_word("o_wb_reg_write", DATA_W'(o_wb_reg_write), DATA_W'(exp.wr));
    if (exp.wr) begin
      check_word("o_wb_reg_addr", DATA_W'(o_wb_reg_addr), DATA_W'(exp.addr));
      check_word("o_wb_data", o_wb_data, exp.data);
    end
    close_test(label, errors_before);
  endtask

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  initial begin
    #((NUM_VECTORS + 40) * CLK_PERIOD);
    $display("Watchdog timeout, the run did not complete in time");
    $display("Test failed");
    $finish;
  end

  initial begin
    vector_t           v;
    vector_t           noop;
    logic              saved_wr;
    logic [4:0]        saved_addr;
    logic [DATA_W-1:0] saved_data;
    logic [DATA_W-1:0] dbg_before;
    int                errors_before;

    i_rst_n = 1'b0;
    i_step = 1'b0;
    i_instruction = NOP_INSTR;
    i_dbg_reg_addr = '0;
    noop = '{NOP_INSTR, 1'b1, 1'b0, '0, '0};
    load_vectors();
    if (vectors.size() != NUM_VECTORS) begin
      $display("Vector table holds %0d entries, %0d expected", vectors.size(), NUM_VECTORS);
      error_count++;
    end

    repeat (5) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;
    errors_before = error_count;
    check_word("o_wb_reg_write", DATA_W'(o_wb_reg_write), '0);
    close_test("reset writeback", errors_before);
    sweep_registers("reset registers", 1'b0);

    pending.push_back(noop);  // Writeback holds a no-op out of reset
    pending_name.push_back("reset no-op");
    @(posedge i_clk);
    #1;
    for (int idx = 0; idx < vectors.size(); idx++) begin
      v = vectors[idx];
      i_instruction = v.instr;
      i_step = v.step;
      if (!v.step) begin
        saved_wr = o_wb_reg_write;
        saved_addr = o_wb_reg_addr;
        saved_data = o_wb_data;
        i_dbg_reg_addr = o_wb_reg_addr;  // Pending write target must not change
        #1;
        dbg_before = o_dbg_reg_data;
      end
      @(posedge i_clk);
      #1;
      if (v.step) begin
        pending.push_back(v);
        pending_name.push_back($sformatf("vector %0d", idx));
        check_writeback();
      end else begin
        errors_before = error_count;
        check_word("o_wb_reg_write", DATA_W'(o_wb_reg_write), DATA_W'(saved_wr));
        check_word("o_wb_reg_addr", DATA_W'(o_wb_reg_addr), DATA_W'(saved_addr));
        check_word("o_wb_data", o_wb_data, saved_data);
        check_word("o_dbg_reg_data", o_dbg_reg_data, dbg_before);
        close_test($sformatf("vector %0d stall", idx), errors_before);
      end
    end

    // Drain the last results into the register file
    for (int d = 0; d < 2; d++) begin
      i_instruction = NOP_INSTR;
      i_step = 1'b1;
      @(posedge i_clk);
      #1;
      pending.push_back(noop);
      pending_name.push_back($sformatf("drain %0d", d));
      check_writeback();
    end
    i_step = 1'b0;
    sweep_registers("final registers", 1'b1);

    $display("Summary: %0d tests, %0d failed, %0d mismatches",
             test_count, failed_count, error_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
